/* Makefile */
# Verilator flow for the memory hierarchy.
VERILATOR ?= verilator
FILELIST  ?= list.f
RTL_TOP   ?= mem_hierarchy
TB_TOP    ?= tb_mem_hierarchy
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/cache_port_if.sv
verilog/cache.sv
verilog/unified_mem.sv
verilog/cache_controller.sv
verilog/mem_hierarchy.sv
tb/tb_mem_hierarchy.sv

/* tb/tb_mem_hierarchy.sv */
`timescale 1ns/10ps
`include "mem_defines.svh"

module tb_mem_hierarchy;
	import mem_pkg::*;

	localparam int NUM_ACCESSES = 55; // 1 + 8 + 3 + 2 + 1 + 40 processor accesses.
	localparam int WATCHDOG_NS = NUM_ACCESSES * (2 * `MEM_LATENCY + 4) * 4 * 2;

	logic clk;
	logic i_rst_n;
	logic i_instr_acc;
	word_t i_instr_addr;
	logic i_data_rd;
	logic i_data_wr;
	word_t i_data_addr;
	word_t i_data_wdata;
	logic o_stall;
	word_t o_instr;
	word_t o_data;

	word_t ref_mem [65536]; // processor view of data memory.
	word_t main_img [65536]; // main memory as the instruction port sees it.
	tag_t dc_tag [64]; // data lines written but not yet evicted are tracked here.
	logic [63:0] dc_valid;
	logic [63:0] dc_dirty;
	integer seed;

	mem_hierarchy u_mem_hierarchy (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_instr_acc (i_instr_acc),
		.i_instr_addr (i_instr_addr),
		.i_data_rd (i_data_rd),
		.i_data_wr (i_data_wr),
		.i_data_addr (i_data_addr),
		.i_data_wdata (i_data_wdata),
		.o_stall (o_stall),
		.o_instr (o_instr),
		.o_data (o_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
		$display("Test failed");
		$fatal(1);
	end

	task automatic check_word(input word_t got, input word_t exp, input string msg);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s returned %h, expected %h.", $time, msg, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic check_stall(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s gave stall %b, expected %b.", $time, msg, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	function automatic word_t rand_word();
		integer r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// Mirrors the write-back policy so that main memory contents can be predicted.
	task automatic track_data(input word_t addr, input logic wr, input word_t wdata);
		logic [`MEM_INDEX_BITS-1:0] idx;
		tag_t tag;
		idx = addr[7:2];
		tag = addr[15:8];
		if (!dc_valid[idx] || dc_tag[idx] != tag) begin
			if (dc_valid[idx] && dc_dirty[idx]) begin
				for (int k = 0; k < 4; k++) begin
					main_img[{dc_tag[idx], idx, 2'(k)}] = ref_mem[{dc_tag[idx], idx, 2'(k)}];
				end
			end
			dc_valid[idx] = 1'b1;
			dc_tag[idx] = tag;
			dc_dirty[idx] = 1'b0;
		end
		if (wr) begin
			ref_mem[addr] = wdata;
			dc_dirty[idx] = 1'b1;
		end
	endtask

	// One processor access, held until the stall drops.
	task automatic run_access(input logic iacc, input word_t iaddr, input logic rd, input logic wr,
		input word_t daddr, input word_t wdata, output logic stalled, output word_t iword,
		output word_t dword);
		@(negedge clk);
		i_instr_acc = iacc;
		i_instr_addr = iaddr;
		i_data_rd = rd;
		i_data_wr = wr;
		i_data_addr = daddr;
		i_data_wdata = wdata;
		#1;
		stalled = o_stall;
		while (o_stall) begin
			@(negedge clk);
			#1;
		end
		iword = o_instr; // outputs are settled well before the next rising edge.
		dword = o_data;
		@(posedge clk); // a pending write is performed at this edge.
		@(negedge clk);
		i_instr_acc = 1'b0;
		i_data_rd = 1'b0;
		i_data_wr = 1'b0;
	endtask

	task automatic data_read(input word_t addr, output logic stalled);
		word_t iw;
		word_t dw;
		run_access(1'b0, 16'h0000, 1'b1, 1'b0, addr, 16'h0000, stalled, iw, dw);
		check_word(dw, ref_mem[addr], $sformatf("data read at %h", addr));
		track_data(addr, 1'b0, 16'h0000);
	endtask

	task automatic data_write(input word_t addr, input word_t wdata, output logic stalled);
		word_t iw;
		word_t dw;
		run_access(1'b0, 16'h0000, 1'b0, 1'b1, addr, wdata, stalled, iw, dw);
		track_data(addr, 1'b1, wdata);
	endtask

	task automatic instr_fetch(input word_t addr, output logic stalled);
		word_t iw;
		word_t dw;
		run_access(1'b1, addr, 1'b0, 1'b0, 16'h0000, 16'h0000, stalled, iw, dw);
		check_word(iw, main_img[addr], $sformatf("instruction fetch at %h", addr));
	endtask

	task automatic reset_then_read();
		logic st;
		#1;
		check_stall(o_stall, 1'b0, "idle hierarchy after reset");
		data_read(16'h1234, st);
		check_stall(st, 1'b1, "first data read");
	endtask

	task automatic fill_one_line();
		logic st;
		for (int k = 0; k < 4; k++) begin
			data_write({14'h0090, 2'(k)}, rand_word(), st);
			check_stall(st, k == 0, "write to line 0x0240"); // only the allocating write misses.
		end
		for (int k = 0; k < 4; k++) begin
			data_read({14'h0090, 2'(k)}, st);
			check_stall(st, 1'b0, "read back of line 0x0240");
		end
	endtask

	task automatic evict_on_conflict();
		logic st;
		data_write(16'h0A85, rand_word(), st);
		data_read(16'h3385, st); // same index, other tag.
		check_stall(st, 1'b1, "conflicting data read");
		data_read(16'h0A85, st);
		check_stall(st, 1'b1, "read of the evicted line");
	endtask

	task automatic fetch_after_writeback();
		logic st;
		instr_fetch(16'h0A85, st);
		check_stall(st, 1'b1, "fetch of a written back line");
		instr_fetch(16'h7700, st);
	endtask

	task automatic miss_on_both_ports();
		logic st;
		word_t iw;
		word_t dw;
		// the data read evicts the dirty line 0x0240, which the fetch still sees as zero.
		run_access(1'b1, 16'h0241, 1'b1, 1'b0, 16'h5540, 16'h0000, st, iw, dw);
		check_stall(st, 1'b1, "double miss");
		check_word(iw, main_img[16'h0241], "instruction fetch during a double miss");
		check_word(dw, ref_mem[16'h5540], "data read during a double miss");
		track_data(16'h5540, 1'b0, 16'h0000);
	endtask

	task automatic random_collisions();
		integer r;
		word_t addr;
		logic st;
		for (int n = 0; n < 40; n++) begin
			r = $random(seed);
			addr = {4'h1, 2'b00, r[1:0], 6'h2A, r[5:4]}; // four tags fight over one index.
			if (r[8]) begin
				data_write(addr, rand_word(), st);
			end else begin
				data_read(addr, st);
			end
		end
	endtask

	initial begin
		seed = 60;
		i_rst_n = 1'b0;
		i_instr_acc = 1'b0;
		i_instr_addr = '0;
		i_data_rd = 1'b0;
		i_data_wr = 1'b0;
		i_data_addr = '0;
		i_data_wdata = '0;
		dc_valid = '0;
		dc_dirty = '0;
		for (int i = 0; i < 65536; i++) begin
			ref_mem[16'(i)] = '0;
			main_img[16'(i)] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;
		reset_then_read();
		fill_one_line();
		evict_on_conflict();
		fetch_after_writeback();
		miss_on_both_ports();
		random_collisions();
		$display("Test passed");
		$finish;
	end

endmodule

/* verilog/cache.sv */
`timescale 1ns/10ps
`include "mem_defines.svh"

module cache (
	input logic clk,
	input logic i_rst_n,
	input mem_pkg::word_t i_addr,
	input logic i_acc,
	cache_port_if.cache port,
	output mem_pkg::word_t o_word
);
	import mem_pkg::*;

	localparam int LINES = 1 << `MEM_INDEX_BITS;
	localparam int OFFSET_BITS = $clog2(`MEM_LINE_WORDS);

	logic [`MEM_INDEX_BITS-1:0] index;
	tag_t addr_tag;
	logic [OFFSET_BITS-1:0] offset;

	tag_t tag_mem [LINES];
	cache_line_u data_mem [LINES];
	logic [LINES-1:0] line_valid;
	logic [LINES-1:0] line_dirty;

	assign offset = i_addr[OFFSET_BITS-1:0];
	assign index = i_addr[OFFSET_BITS +: `MEM_INDEX_BITS];
	assign addr_tag = i_addr[OFFSET_BITS+`MEM_INDEX_BITS +: `MEM_TAG_BITS];

	// Everything below is read straight out of the arrays, no clock involved.
	assign port.hit = i_acc & line_valid[index] & (tag_mem[index] == addr_tag);
	assign port.dirty = line_valid[index] & line_dirty[index]; // an invalid line is never dirty.
	assign port.tag = tag_mem[index];
	assign port.rd_line = data_mem[index];
	assign o_word = port.rd_line.words[offset]; // offset picks the word out of the line.

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			line_valid <= '0;
			line_dirty <= '0;
		end else if (port.we) begin
			line_valid[index] <= 1'b1;
			line_dirty[index] <= port.wdirty;
		end
	end

	// The controller always writes the line the current address points at.
	always_ff @(posedge clk) begin
		if (port.we) begin
			tag_mem[index] <= addr_tag;
			data_mem[index] <= port.wr_line;
		end
	end

	// The controller must keep its strobes quiet while the hierarchy is held in reset.
	a_no_write_in_reset: assert property (@(posedge clk) !i_rst_n |-> !port.we);

endmodule

/* verilog/cache_controller.sv */
`timescale 1ns/10ps
`include "mem_defines.svh"

module cache_controller (
	input logic clk,
	input logic i_rst_n,
	input logic i_instr_acc,
	input mem_pkg::word_t i_instr_addr,
	input logic i_data_rd,
	input logic i_data_wr,
	input mem_pkg::word_t i_data_addr,
	input mem_pkg::word_t i_data_wdata,
	input mem_pkg::cache_line_u i_mem_rdata,
	input logic i_mem_rdy,
	output logic o_mem_re,
	output logic o_mem_we,
	output mem_pkg::line_addr_t o_mem_addr,
	output mem_pkg::cache_line_u o_mem_wdata,
	output logic o_stall,
	cache_port_if.ctrl iport,
	cache_port_if.ctrl dport
);
	import mem_pkg::*;

	localparam int OFFSET_BITS = $clog2(`MEM_LINE_WORDS);
	localparam int INDEX_LSB = OFFSET_BITS;
	localparam int INDEX_MSB = OFFSET_BITS + `MEM_INDEX_BITS - 1;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WRITEBACK = 2'd1;
	localparam logic [1:0] ST_FILL_INSTR = 2'd2;
	localparam logic [1:0] ST_FILL_DATA = 2'd3;

	logic [1:0] state;
	logic [1:0] next_state;
	logic [1:0] data_miss_state;
	logic instr_miss;
	logic data_miss;
	logic write_hit;
	cache_line_u merged_line;

	assign instr_miss = i_instr_acc & ~iport.hit;
	assign data_miss = (i_data_rd | i_data_wr) & ~dport.hit;
	assign o_stall = instr_miss | data_miss | (state != ST_IDLE);

	// A write is only performed once nothing else holds the processor.
	assign write_hit = i_data_wr & dport.hit & ~o_stall;

	// A dirty victim has to go out to memory before its slot is refilled.
	assign data_miss_state = dport.dirty ? ST_WRITEBACK : ST_FILL_DATA;

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (instr_miss) begin
					next_state = ST_FILL_INSTR; // instruction misses go first.
				end else if (data_miss) begin
					next_state = data_miss_state;
				end
			end
			ST_WRITEBACK: begin
				if (i_mem_rdy) begin
					next_state = ST_FILL_DATA;
				end
			end
			ST_FILL_INSTR: begin
				if (i_mem_rdy) begin
					next_state = data_miss ? data_miss_state : ST_IDLE;
				end
			end
			default: begin
				if (i_mem_rdy) begin
					next_state = ST_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Memory side.
	always_comb begin
		o_mem_re = 1'b0;
		o_mem_we = 1'b0;
		o_mem_addr = i_data_addr[15:OFFSET_BITS];
		case (state)
			ST_WRITEBACK: begin
				o_mem_we = 1'b1;
				o_mem_addr = {dport.tag, i_data_addr[INDEX_MSB:INDEX_LSB]}; // victim's own address.
			end
			ST_FILL_INSTR: begin
				o_mem_re = 1'b1;
				o_mem_addr = i_instr_addr[15:OFFSET_BITS];
			end
			ST_FILL_DATA: begin
				o_mem_re = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign o_mem_wdata = dport.rd_line;

	// Write data replaces one word of the line that is already cached.
	always_comb begin
		merged_line = dport.rd_line;
		merged_line.words[i_data_addr[OFFSET_BITS-1:0]] = i_data_wdata;
	end

	assign iport.we = (state == ST_FILL_INSTR) & i_mem_rdy;
	assign iport.wdirty = 1'b0;
	assign iport.wr_line = i_mem_rdata;

	assign dport.we = ((state == ST_FILL_DATA) & i_mem_rdy) | write_hit;
	assign dport.wdirty = write_hit; // refills land clean.
	assign dport.wr_line = write_hit ? merged_line : i_mem_rdata;

	// The instruction cache is read only, so none of its lines may ever turn dirty.
	a_icache_clean: assert property (@(posedge clk) disable iff (!i_rst_n) !iport.dirty);

endmodule

/* verilog/cache_port_if.sv */
`timescale 1ns/10ps

interface cache_port_if;
	import mem_pkg::*;

	logic we; // fill or write strobe from the controller.
	logic wdirty; // dirty bit stored along with the write.
	cache_line_u wr_line;

	logic hit;
	logic dirty; // dirty bit of the indexed line.
	tag_t tag; // tag of the indexed line.
	cache_line_u rd_line;

	modport cache (
		input we, wdirty, wr_line,
		output hit, dirty, tag, rd_line
	);

	modport ctrl (
		output we, wdirty, wr_line,
		input hit, dirty, tag, rd_line
	);

endinterface

/* verilog/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Cache geometry, shared by both caches and the miss controller.
`define MEM_LINE_WORDS 4 // words per cache line.
`define MEM_INDEX_BITS 6 // 64 lines per cache.
`define MEM_TAG_BITS 8 // upper bits of the word address.

// Main memory access time in clock cycles.
`define MEM_LATENCY 4

`endif

/* verilog/mem_hierarchy.sv */
`timescale 1ns/10ps

module mem_hierarchy (
	input logic clk,
	input logic i_rst_n,
	input logic i_instr_acc,
	input mem_pkg::word_t i_instr_addr,
	input logic i_data_rd,
	input logic i_data_wr,
	input mem_pkg::word_t i_data_addr,
	input mem_pkg::word_t i_data_wdata,
	output logic o_stall,
	output mem_pkg::word_t o_instr,
	output mem_pkg::word_t o_data
);
	import mem_pkg::*;

	logic mem_re;
	logic mem_we;
	logic mem_rdy;
	line_addr_t mem_addr;
	cache_line_u mem_wdata;
	cache_line_u mem_rdata;

	cache_port_if iport ();
	cache_port_if dport ();

	cache u_icache (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_addr (i_instr_addr),
		.i_acc (i_instr_acc),
		.port (iport),
		.o_word (o_instr)
	);

	cache u_dcache (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_addr (i_data_addr),
		.i_acc (i_data_rd | i_data_wr), // a write also needs its line present.
		.port (dport),
		.o_word (o_data)
	);

	unified_mem u_main_mem (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_re (mem_re),
		.i_we (mem_we),
		.i_addr (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata),
		.o_rdy (mem_rdy)
	);

	cache_controller u_controller (
		.clk (clk),
		.i_rst_n (i_rst_n),
		.i_instr_acc (i_instr_acc),
		.i_instr_addr (i_instr_addr),
		.i_data_rd (i_data_rd),
		.i_data_wr (i_data_wr),
		.i_data_addr (i_data_addr),
		.i_data_wdata (i_data_wdata),
		.i_mem_rdata (mem_rdata),
		.i_mem_rdy (mem_rdy),
		.o_mem_re (mem_re),
		.o_mem_we (mem_we),
		.o_mem_addr (mem_addr),
		.o_mem_wdata (mem_wdata),
		.o_stall (o_stall),
		.iport (iport),
		.dport (dport)
	);

endmodule

/* verilog/mem_pkg.sv */
`include "mem_defines.svh"

package mem_pkg;

	typedef logic [15:0] word_t; // processor word, also the word address.

	typedef logic [`MEM_TAG_BITS-1:0] tag_t;

	// Word address with the in-line offset stripped off.
	typedef logic [`MEM_TAG_BITS+`MEM_INDEX_BITS-1:0] line_addr_t;

	// One cache line.
	// Memory and controller move it as a raw vector, caches pick words out of it.
	typedef union packed {
		logic [`MEM_LINE_WORDS*16-1:0] raw;
		word_t [`MEM_LINE_WORDS-1:0] words; // word 0 sits in the low bits.
	} cache_line_u;

endpackage

/* verilog/unified_mem.sv */
`timescale 1ns/10ps
`include "mem_defines.svh"

module unified_mem (
	input logic clk,
	input logic i_rst_n,
	input logic i_re,
	input logic i_we,
	input mem_pkg::line_addr_t i_addr,
	input mem_pkg::cache_line_u i_wdata,
	output mem_pkg::cache_line_u o_rdata,
	output logic o_rdy
);
	import mem_pkg::*;

	localparam int DEPTH = 1 << (`MEM_TAG_BITS + `MEM_INDEX_BITS);
	localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);

	cache_line_u mem [DEPTH];
	logic busy;
	logic [CNT_BITS-1:0] count;
	logic done;

	// The processor sees an all-zero memory after power up.
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	assign done = busy & (count == '0);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			count <= '0;
			o_rdy <= 1'b0;
		end else begin
			o_rdy <= done; // one-cycle pulse after the last wait cycle.
			if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				count <= count - 1'b1;
			end else if ((i_re | i_we) & ~o_rdy) begin // the request is still up while rdy is high.
				busy <= 1'b1;
				count <= CNT_BITS'(`MEM_LATENCY - 1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (done && i_we) begin
			mem[i_addr] <= i_wdata;
		end
		if (done && i_re) begin
			o_rdata <= mem[i_addr]; // valid during the rdy cycle.
		end
	end

	a_no_read_write: assert property (@(posedge clk) disable iff (!i_rst_n) !(i_re && i_we));

	// A request must not move while the access is in flight.
	a_addr_stable: assert property (@(posedge clk) disable iff (!i_rst_n) busy |-> $stable(i_addr));

endmodule
